// File: Makefile
# Verilator build and run of the dehazing testbench

VERILATOR ?= verilator
TOP       ?= dehaze_tb
FILELIST  ?= build.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

BIN  := $(BUILD_DIR)/V$(TOP)
SRCS := $(shell cat $(FILELIST))

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run, and search $(LOG) for the result"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

$(BIN): $(FILELIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

test: $(BIN)
	@$(BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "SIMULATION FAILED" $(LOG); then \
		echo "Test failed, see $(LOG)"; exit 1; \
	elif ! grep -q "SIMULATION PASSED" $(LOG); then \
		echo "No result found in $(LOG)"; exit 1; \
	else \
		echo "Test passed"; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: build.f
hdl/dehaze_pixel_pkg.sv
hdl/dehaze_fixed_pkg.sv
hdl/transmission_estimator.sv
hdl/channel_offset_path.sv
hdl/scene_recovery.sv
hdl/dehaze_core.sv
verif/dehaze_tb.sv

// File: hdl/channel_offset_path.sv
// Three-stage pipeline for per-channel offset from the light, its direction and the light
`timescale 1ns/1ps
`default_nettype none

module channel_offset_path (
    input  wire                          clk,
    input  wire                          in_valid,
    input  wire dehaze_pixel_pkg::rgb_t  centre,
    input  wire dehaze_pixel_pkg::chan_t a_r,
    input  wire dehaze_pixel_pkg::chan_t a_g,
    input  wire dehaze_pixel_pkg::chan_t a_b,
    output dehaze_pixel_pkg::chan_t      offset_r,
    output dehaze_pixel_pkg::chan_t      offset_g,
    output dehaze_pixel_pkg::chan_t      offset_b,
    output logic                         brighter_r,
    output logic                         brighter_g,
    output logic                         brighter_b,
    output dehaze_pixel_pkg::chan_t      light_r,
    output dehaze_pixel_pkg::chan_t      light_g,
    output dehaze_pixel_pkg::chan_t      light_b
);
    import dehaze_pixel_pkg::*;

    // Arrays are indexed blue 0, green 1, red 2
    chan_t      light [3];
    chan_t      off_s1 [3];
    chan_t      off_s2 [3];
    chan_t      off_s3 [3];
    chan_t      lt_s1 [3];
    chan_t      lt_s2 [3];
    chan_t      lt_s3 [3];
    logic [2:0] up_s1;
    logic [2:0] up_s2;
    logic [2:0] up_s3;
    logic [2:0] v_q;

    assign light = '{a_b, a_g, a_r};

    // |I - A| and its sign, captured only for a valid window
    always_ff @(posedge clk) begin
        if (in_valid) begin
            for (int c = 0; c < 3; c++) begin
                up_s1[c]  <= centre[8*c +: 8] >= light[c];
                off_s1[c] <= (centre[8*c +: 8] >= light[c]) ? centre[8*c +: 8] - light[c]
                                                            : light[c] - centre[8*c +: 8];
                lt_s1[c]  <= light[c];
            end
        end
    end

    // Two more stages to line up with the reciprocal of the transmission
    always_ff @(posedge clk) begin
        off_s2 <= off_s1;
        off_s3 <= off_s2;
        up_s2  <= up_s1;
        up_s3  <= up_s2;
        lt_s2  <= lt_s1;
        lt_s3  <= lt_s2;
        v_q    <= {v_q[1:0], in_valid};
    end

    assign offset_r   = off_s3[CH_RED];
    assign offset_g   = off_s3[CH_GREEN];
    assign offset_b   = off_s3[CH_BLUE];
    assign brighter_r = up_s3[CH_RED];
    assign brighter_g = up_s3[CH_GREEN];
    assign brighter_b = up_s3[CH_BLUE];
    assign light_r    = lt_s3[CH_RED];
    assign light_g    = lt_s3[CH_GREEN];
    assign light_b    = lt_s3[CH_BLUE];

    // A darker-than-light channel always leaves a nonzero offset
    a_dark_offset: assert property (@(posedge clk)
        v_q[2] |-> (brighter_r || offset_r != 8'd0) && (brighter_g || offset_g != 8'd0)
                   && (brighter_b || offset_b != 8'd0));

endmodule

`default_nettype wire

// File: hdl/dehaze_core.sv
// Dehazing back end joining transmission estimation, channel offset and scene recovery
`timescale 1ns/1ps
`default_nettype none

module dehaze_core #(
    parameter int omega_shift = dehaze_fixed_pkg::DEF_OMEGA_SHIFT,
    parameter int t_min       = dehaze_fixed_pkg::DEF_T_MIN
) (
    input  wire                          clk,
    input  wire                          rst,
    input  wire                          in_valid,
    input  wire dehaze_pixel_pkg::rgb_t  win_0,
    input  wire dehaze_pixel_pkg::rgb_t  win_1,
    input  wire dehaze_pixel_pkg::rgb_t  win_2,
    input  wire dehaze_pixel_pkg::rgb_t  win_3,
    input  wire dehaze_pixel_pkg::rgb_t  win_4,
    input  wire dehaze_pixel_pkg::rgb_t  win_5,
    input  wire dehaze_pixel_pkg::rgb_t  win_6,
    input  wire dehaze_pixel_pkg::rgb_t  win_7,
    input  wire dehaze_pixel_pkg::rgb_t  win_8,
    input  wire dehaze_pixel_pkg::chan_t a_r,
    input  wire dehaze_pixel_pkg::chan_t a_g,
    input  wire dehaze_pixel_pkg::chan_t a_b,
    input  wire dehaze_fixed_pkg::q10_t  inv_a_r,
    input  wire dehaze_fixed_pkg::q10_t  inv_a_g,
    input  wire dehaze_fixed_pkg::q10_t  inv_a_b,
    output dehaze_pixel_pkg::rgb_t       out_pixel,
    output logic                         out_valid
);
    import dehaze_pixel_pkg::*;
    import dehaze_fixed_pkg::*;

    inv_trans_t inv_trans;
    logic       trans_valid;
    chan_t      offset_r;
    chan_t      offset_g;
    chan_t      offset_b;
    logic       brighter_r;
    logic       brighter_g;
    logic       brighter_b;
    chan_t      light_r;
    chan_t      light_g;
    chan_t      light_b;

    // ==============================
    // Transmission path, 3 cycles
    // ==============================
    transmission_estimator #(
        .omega_shift (omega_shift),
        .t_min       (t_min)
    ) i_trans (
        .clk         (clk),
        .rst         (rst),
        .in_valid    (in_valid),
        .win_0       (win_0),
        .win_1       (win_1),
        .win_2       (win_2),
        .win_3       (win_3),
        .win_4       (win_4),
        .win_5       (win_5),
        .win_6       (win_6),
        .win_7       (win_7),
        .win_8       (win_8),
        .inv_a_r     (inv_a_r),
        .inv_a_g     (inv_a_g),
        .inv_a_b     (inv_a_b),
        .inv_trans   (inv_trans),
        .trans_valid (trans_valid)
    );

    // Offset path runs alongside, same depth
    channel_offset_path i_offset (
        .clk        (clk),
        .in_valid   (in_valid),
        .centre     (win_4),
        .a_r        (a_r),
        .a_g        (a_g),
        .a_b        (a_b),
        .offset_r   (offset_r),
        .offset_g   (offset_g),
        .offset_b   (offset_b),
        .brighter_r (brighter_r),
        .brighter_g (brighter_g),
        .brighter_b (brighter_b),
        .light_r    (light_r),
        .light_g    (light_g),
        .light_b    (light_b)
    );

    // ==============================
    // Recovery, 1 cycle
    // ==============================
    scene_recovery i_recover (
        .clk         (clk),
        .rst         (rst),
        .trans_valid (trans_valid),
        .inv_trans   (inv_trans),
        .offset_r    (offset_r),
        .offset_g    (offset_g),
        .offset_b    (offset_b),
        .brighter_r  (brighter_r),
        .brighter_g  (brighter_g),
        .brighter_b  (brighter_b),
        .light_r     (light_r),
        .light_g     (light_g),
        .light_b     (light_b),
        .out_pixel   (out_pixel),
        .out_valid   (out_valid)
    );

endmodule

`default_nettype wire

// File: hdl/dehaze_fixed_pkg.sv
// Fixed-point types and default tuning constants for the transmission arithmetic
`default_nettype none

package dehaze_fixed_pkg;

    // ==============================
    // Fixed-point formats
    // ==============================

    // Unsigned Q1.10, 1.0 is 1024
    // holds inverse light, dark channel product and transmission
    typedef logic [10:0] q10_t;

    // Unsigned Q4.4 inverse transmission, 1.0 is 16
    typedef logic [7:0] inv_trans_t;

    // ==============================
    // Default tuning
    // ==============================

    // Omega = 1 - 2^-DEF_OMEGA_SHIFT, so 15/16 by default
    localparam int DEF_OMEGA_SHIFT = 4;

    // Lower clamp on the transmission, roughly 0.1 in Q1.10
    localparam int DEF_T_MIN = 103;

endpackage

`default_nettype wire

// File: hdl/dehaze_pixel_pkg.sv
// Pixel and colour channel types for the dehazing pipeline
`default_nettype none

package dehaze_pixel_pkg;

    // ==============================
    // Colour data
    // ==============================

    // One 8-bit colour channel
    typedef logic [7:0] chan_t;

    // RGB888 pixel, red in [23:16], green in [15:8], blue in [7:0]
    typedef logic [23:0] rgb_t;

    // Channel positions inside rgb_t, in units of one channel
    localparam int CH_BLUE  = 0;
    localparam int CH_GREEN = 1;
    localparam int CH_RED   = 2;

endpackage

`default_nettype wire

// File: hdl/scene_recovery.sv
// One-stage scene recovery combining offsets, light and inverse transmission
`timescale 1ns/1ps
`default_nettype none

module scene_recovery (
    input  wire                              clk,
    input  wire                              rst,
    input  wire                              trans_valid,
    input  wire dehaze_fixed_pkg::inv_trans_t inv_trans,
    input  wire dehaze_pixel_pkg::chan_t     offset_r,
    input  wire dehaze_pixel_pkg::chan_t     offset_g,
    input  wire dehaze_pixel_pkg::chan_t     offset_b,
    input  wire                              brighter_r,
    input  wire                              brighter_g,
    input  wire                              brighter_b,
    input  wire dehaze_pixel_pkg::chan_t     light_r,
    input  wire dehaze_pixel_pkg::chan_t     light_g,
    input  wire dehaze_pixel_pkg::chan_t     light_b,
    output dehaze_pixel_pkg::rgb_t           out_pixel,
    output logic                             out_valid
);
    import dehaze_pixel_pkg::*;
    import dehaze_fixed_pkg::*;

    chan_t rec_r;
    chan_t rec_g;
    chan_t rec_b;

    // J = A +/- |I - A| / t, saturated to 0..255
    function automatic chan_t recover(input chan_t offset, input logic brighter,
                                      input chan_t light, input inv_trans_t inv_t);
        logic [15:0] prod;
        logic [11:0] scaled;
        chan_t       step;
        logic [8:0]  sum;

        prod   = {8'd0, offset} * {8'd0, inv_t};
        scaled = prod[15:4];
        step   = (scaled > 12'd255) ? 8'd255 : scaled[7:0];
        if (brighter) begin
            sum = {1'b0, light} + {1'b0, step};
            return sum[8] ? 8'd255 : sum[7:0];
        end
        return (light < step) ? 8'd0 : light - step;
    endfunction

    always_comb begin
        rec_r = recover(offset_r, brighter_r, light_r, inv_trans);
        rec_g = recover(offset_g, brighter_g, light_g, inv_trans);
        rec_b = recover(offset_b, brighter_b, light_b, inv_trans);
    end

    always_ff @(posedge clk) begin
        out_pixel <= {rec_r, rec_g, rec_b};
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= trans_valid;
        end
    end

    // every delivered pixel is fully defined
    a_out_known: assert property (@(posedge clk) disable iff (rst)
        out_valid |-> !$isunknown(out_pixel));

endmodule

`default_nettype wire

// File: hdl/transmission_estimator.sv
// Three-stage pipeline from a 3x3 window and inverse light to the inverse transmission
`timescale 1ns/1ps
`default_nettype none

module transmission_estimator #(
    parameter int omega_shift = dehaze_fixed_pkg::DEF_OMEGA_SHIFT,
    parameter int t_min       = dehaze_fixed_pkg::DEF_T_MIN
) (
    input  wire                          clk,
    input  wire                          rst,
    input  wire                          in_valid,
    input  wire dehaze_pixel_pkg::rgb_t  win_0,
    input  wire dehaze_pixel_pkg::rgb_t  win_1,
    input  wire dehaze_pixel_pkg::rgb_t  win_2,
    input  wire dehaze_pixel_pkg::rgb_t  win_3,
    input  wire dehaze_pixel_pkg::rgb_t  win_4,
    input  wire dehaze_pixel_pkg::rgb_t  win_5,
    input  wire dehaze_pixel_pkg::rgb_t  win_6,
    input  wire dehaze_pixel_pkg::rgb_t  win_7,
    input  wire dehaze_pixel_pkg::rgb_t  win_8,
    input  wire dehaze_fixed_pkg::q10_t  inv_a_r,
    input  wire dehaze_fixed_pkg::q10_t  inv_a_g,
    input  wire dehaze_fixed_pkg::q10_t  inv_a_b,
    output dehaze_fixed_pkg::inv_trans_t inv_trans,
    output logic                         trans_valid
);
    import dehaze_pixel_pkg::*;
    import dehaze_fixed_pkg::*;

    localparam q10_t q10_one = 11'd1024;

    rgb_t        win [9];
    chan_t       filt_d [3];
    chan_t       filt_q [3];
    q10_t        inv_sc_r_q;
    q10_t        inv_sc_g_q;
    q10_t        inv_sc_b_q;
    logic        s1_valid;
    logic        s2_valid;
    chan_t       min_f;
    q10_t        min_inv;
    logic [18:0] prod;
    q10_t        prod_q;
    q10_t        trans;
    logic [14:0] quot;

    function automatic logic [11:0] widen(input chan_t v);
        return {4'd0, v};
    endfunction

    assign win = '{win_0, win_1, win_2, win_3, win_4, win_5, win_6, win_7, win_8};

    // ==============================
    // Stage 1, smoothing and omega/A
    // ==============================

    // Kernel 1-2-1 / 2-4-2 / 1-2-1, sum of weights is 16
    for (genvar c = 0; c < 3; c++) begin : g_filter
        logic [11:0] corners;
        logic [11:0] edges;
        logic [11:0] sum;

        assign corners = widen(win[0][8*c +: 8]) + widen(win[2][8*c +: 8])
                       + widen(win[6][8*c +: 8]) + widen(win[8][8*c +: 8]);
        assign edges   = widen(win[1][8*c +: 8]) + widen(win[3][8*c +: 8])
                       + widen(win[5][8*c +: 8]) + widen(win[7][8*c +: 8]);
        assign sum     = corners + (edges << 1) + (widen(win[4][8*c +: 8]) << 2);
        assign filt_d[c] = sum[11:4];
    end

    always_ff @(posedge clk) begin
        filt_q     <= filt_d;
        inv_sc_r_q <= inv_a_r - (inv_a_r >> omega_shift);
        inv_sc_g_q <= inv_a_g - (inv_a_g >> omega_shift);
        inv_sc_b_q <= inv_a_b - (inv_a_b >> omega_shift);
    end

    // ==============================
    // Stage 2, dark channel product
    // ==============================

    // Ties resolve to red first, then green
    always_comb begin
        if (filt_q[CH_RED] <= filt_q[CH_GREEN] && filt_q[CH_RED] <= filt_q[CH_BLUE]) begin
            min_f   = filt_q[CH_RED];
            min_inv = inv_sc_r_q;
        end else if (filt_q[CH_GREEN] <= filt_q[CH_BLUE]) begin
            min_f   = filt_q[CH_GREEN];
            min_inv = inv_sc_g_q;
        end else begin
            min_f   = filt_q[CH_BLUE];
            min_inv = inv_sc_b_q;
        end
        prod = {11'd0, min_f} * {8'd0, min_inv};
    end

    always_ff @(posedge clk) begin
        prod_q <= (prod > 19'd1024) ? q10_one : prod[10:0];
    end

    // ==============================
    // Stage 3, clamp and reciprocal
    // ==============================

    always_comb begin
        trans = q10_one - prod_q;
        if (trans < q10_t'(t_min)) begin
            trans = q10_t'(t_min);
        end
        // Q4.4 result of 1.0 / t
        quot = 15'd16384 / {4'd0, trans};
    end

    always_ff @(posedge clk) begin
        inv_trans <= quot[7:0];
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            s1_valid    <= 1'b0;
            s2_valid    <= 1'b0;
            trans_valid <= 1'b0;
        end else begin
            s1_valid    <= in_valid;
            s2_valid    <= s1_valid;
            trans_valid <= s2_valid;
        end
    end

    // Smallest allowed transmission must keep 16384/t below 256
    a_t_min_floor: assert property (@(posedge clk) disable iff (rst) t_min >= 65);

    // reciprocal of a valid result never overflows inv_trans
    a_inv_trans_fits: assert property (@(posedge clk) disable iff (rst)
        s2_valid |-> quot[14:8] == 7'd0);

endmodule

`default_nettype wire

// File: verif/dehaze_tb.sv
// Testbench for dehaze_core with clock, reset, stimulus, reference model, scoreboard and timeout
`timescale 1ns/1ps
`default_nettype none

module dehaze_tb;
    import dehaze_pixel_pkg::*;
    import dehaze_fixed_pkg::*;

    localparam int omega_shift  = DEF_OMEGA_SHIFT;
    localparam int t_min        = DEF_T_MIN;
    localparam int reset_cycles = 16;
    localparam int n_directed   = 10;
    localparam int idle_budget  = 40;
    localparam int n_random     = 300;
    localparam int n_gapped     = 100;
    localparam int max_gap      = 3;
    localparam int stim_cycles  = idle_budget + n_directed + n_random + n_gapped * (max_gap + 1);
    localparam int cycle_limit  = reset_cycles + 4 + stim_cycles + 200;

    logic       clk;
    logic       rst;
    logic       in_valid;
    rgb_t [8:0] win;
    chan_t      a_r;
    chan_t      a_g;
    chan_t      a_b;
    q10_t       inv_a_r;
    q10_t       inv_a_g;
    q10_t       inv_a_b;
    rgb_t       out_pixel;
    logic       out_valid;

    rgb_t        exp_q [$];
    string       name_q [$];
    int          due_q [$];
    logic [31:0] rng_state;
    int          errors = 0;
    int          sent = 0;
    int          checked = 0;
    int          cycle_count = 0;

    dehaze_core #(
        .omega_shift (omega_shift),
        .t_min       (t_min)
    ) i_dut (
        .clk (clk), .rst (rst), .in_valid (in_valid),
        .win_0 (win[0]), .win_1 (win[1]), .win_2 (win[2]),
        .win_3 (win[3]), .win_4 (win[4]), .win_5 (win[5]),
        .win_6 (win[6]), .win_7 (win[7]), .win_8 (win[8]),
        .a_r (a_r), .a_g (a_g), .a_b (a_b),
        .inv_a_r (inv_a_r), .inv_a_g (inv_a_g), .inv_a_b (inv_a_b),
        .out_pixel (out_pixel), .out_valid (out_valid)
    );

    always #20 clk = ~clk;

    // ==============================
    // Random numbers and helpers
    // ==============================

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] next_rand();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    // Light is kept in 64..255
    function automatic chan_t random_light();
        return 8'(64 + next_rand() % 192);
    endfunction

    function automatic q10_t inverse_light(input chan_t a);
        return q10_t'(1024 / int'(a));
    endfunction

    function automatic int chan_of(input rgb_t p, input int c);
        return int'(p[8*c +: 8]);
    endfunction

    // ==============================
    // Reference model
    // ==============================

    function automatic rgb_t expected_pixel(input rgb_t [8:0] w, input chan_t ar,
                                            input chan_t ag, input chan_t ab);
        int   light [3];
        int   filt [3];
        int   inv_sc [3];
        int   inv;
        int   sel;
        int   prod;
        int   trans;
        int   inv_t;
        int   pix;
        int   step;
        int   val;
        rgb_t res;

        light[0] = int'(ab);
        light[1] = int'(ag);
        light[2] = int'(ar);
        for (int c = 0; c < 3; c++) begin
            // Corners x1, edges x2, centre x4, then divide by 16
            val = chan_of(w[0], c) + chan_of(w[2], c) + chan_of(w[6], c) + chan_of(w[8], c);
            val += 2 * (chan_of(w[1], c) + chan_of(w[3], c)
                        + chan_of(w[5], c) + chan_of(w[7], c));
            filt[c] = (val + 4 * chan_of(w[4], c)) / 16;
            inv = 1024 / light[c];
            inv_sc[c] = inv - (inv >> omega_shift);
        end
        // Red wins ties over green and green wins ties over blue
        if (filt[2] <= filt[1] && filt[2] <= filt[0]) sel = 2;
        else if (filt[1] <= filt[0]) sel = 1;
        else sel = 0;
        prod = filt[sel] * inv_sc[sel];
        if (prod > 1024) prod = 1024;
        trans = 1024 - prod;
        if (trans < t_min) trans = t_min;
        inv_t = 16384 / trans;
        for (int c = 0; c < 3; c++) begin
            pix = chan_of(w[4], c);
            step = (pix >= light[c]) ? pix - light[c] : light[c] - pix;
            step = (step * inv_t) / 16;
            if (step > 255) step = 255;
            val = (pix >= light[c]) ? light[c] + step : light[c] - step;
            if (val > 255) val = 255;
            if (val < 0) val = 0;
            res[8*c +: 8] = val[7:0];
        end
        return res;
    endfunction

    // ==============================
    // Stimulus tasks
    // ==============================

    task automatic fill_uniform(input rgb_t p);
        for (int i = 0; i < 9; i++) win[i] = p;
    endtask

    task automatic fill_random();
        logic [31:0] r;
        for (int i = 0; i < 9; i++) begin
            r = next_rand();
            win[i] = r[23:0];
        end
    endtask

    // Holds the window for one cycle from a falling edge
    task automatic send_window(input string name, input chan_t ar, input chan_t ag,
                               input chan_t ab);
        a_r = ar;
        a_g = ag;
        a_b = ab;
        inv_a_r = inverse_light(ar);
        inv_a_g = inverse_light(ag);
        inv_a_b = inverse_light(ab);
        in_valid = 1'b1;
        exp_q.push_back(expected_pixel(win, ar, ag, ab));
        name_q.push_back(name);
        // out_valid follows in_valid by 4 cycles
        due_q.push_back(cycle_count + 4);
        sent++;
        @(negedge clk);
    endtask

    task automatic idle(input int n);
        in_valid = 1'b0;
        repeat (n) @(negedge clk);
    endtask

    // Idle cycles in which no output may appear
    task automatic expect_quiet(input int n, input string phase);
        in_valid = 1'b0;
        repeat (n) begin
            @(negedge clk);
            if (out_valid !== 1'b0) begin
                errors++;
                $display("out_valid is not low %s at %0t", phase, $time);
            end
        end
    endtask

    task automatic finish_run();
        if (exp_q.size() != 0) begin
            errors++;
            $display("%0d expected pixels never came out of the DUT", exp_q.size());
        end
        $display("Errors: %0d, windows sent: %0d, pixels checked: %0d", errors, sent, checked);
        if (errors != 0) begin
            $display("SIMULATION FAILED");
        end else begin
            $display("SIMULATION PASSED");
        end
        $finish;
    endtask

    // ==============================
    // Scoreboard and timeout
    // ==============================

    always @(negedge clk) begin : compare
        rgb_t  exp_pix;
        string name;
        int    due;
        if (!rst && out_valid === 1'b1) begin
            if (exp_q.size() == 0) begin
                errors++;
                $display("out_valid went high with no window pending at %0t", $time);
            end else begin
                exp_pix = exp_q.pop_front();
                name = name_q.pop_front();
                due = due_q.pop_front();
                checked++;
                if (cycle_count != due) begin
                    errors++;
                    $display("** Error %s: expected output cycle %0d actual %0d",
                             name, due, cycle_count);
                end
                if (out_pixel !== exp_pix) begin
                    errors++;
                    $display("** Error %s: expected %06h actual %06h", name, exp_pix, out_pixel);
                end
            end
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= cycle_limit) begin
            errors++;
            $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
            finish_run();
        end
    end

    initial begin
        int gap;
        clk = 1'b0;
        rst = 1'b1;
        in_valid = 1'b0;
        win = '0;
        a_r = 8'd0;
        a_g = 8'd0;
        a_b = 8'd0;
        inv_a_r = '0;
        inv_a_g = '0;
        inv_a_b = '0;
        rng_state = 32'd42;

        expect_quiet(reset_cycles, "during reset");
        rst = 1'b0;
        expect_quiet(6, "before the first window");

        // Window equal to the light
        fill_uniform(24'hB47850);
        send_window("uniform_light", 8'hB4, 8'h78, 8'h50);
        fill_uniform(24'hFF40C8);
        send_window("uniform_light", 8'hFF, 8'h40, 8'hC8);
        idle(4);

        // Black, bright and clamping windows
        fill_uniform(24'h000000);
        send_window("black", 8'd150, 8'd100, 8'd200);
        send_window("black", 8'd64, 8'd255, 8'd90);
        fill_uniform(24'hFFFFFF);
        send_window("bright", 8'd200, 8'd180, 8'd64);
        win[4] = 24'h000000;
        send_window("clamp_low", 8'd200, 8'd200, 8'd200);
        win[4] = 24'hFF00FF;
        send_window("clamp_mixed", 8'd100, 8'd100, 8'd100);
        idle(4);

        // Ties in the darkest filtered channel
        fill_uniform(24'h141414);
        send_window("tie_rgb", 8'd64, 8'd128, 8'd255);
        fill_uniform(24'h602020);
        send_window("tie_gb", 8'd90, 8'd150, 8'd70);
        fill_uniform(24'h181850);
        send_window("tie_rg", 8'd255, 8'd70, 8'd100);
        idle(4);

        for (int i = 0; i < n_random; i++) begin
            fill_random();
            send_window("random", random_light(), random_light(), random_light());
        end

        // Gaps of 0..max_gap idle cycles between windows
        for (int i = 0; i < n_gapped; i++) begin
            fill_random();
            send_window("random_gap", random_light(), random_light(), random_light());
            gap = int'(next_rand() % (max_gap + 1));
            if (gap > 0) idle(gap);
        end

        in_valid = 1'b0;
        while (exp_q.size() != 0) @(negedge clk);
        expect_quiet(8, "after the last output");
        finish_run();
    end

endmodule

`default_nettype wire
